//--- sim.f
+incdir+.
cpc_mem_pkg.sv
boot_if.sv
rom_loader.sv
mf2_freezer.sv
sdram_arbiter.sv
cpc_mem_top.sv
cpc_mem_asserts.sv
tb_checker.sv
tb_cpc_mem.sv

//--- tb_cpc_mem.sv
// CPC memory glue testbench
`include "cpc_mem_macros.svh"

module tb_cpc_mem
	import cpc_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic              clk_sys;
	logic              reset;
	logic              mem_slot;
	bank_t             model;
	logic [1:0]        mf2_mode;
	logic              dl_active;
	byte_t             dl_index;
	logic [15:0]       dl_file_ext;
	logic              dl_wr;
	logic [`DL_AW-1:0] dl_addr;
	byte_t             dl_data;
	logic              dl_wait;
	logic              key_nmi;
	logic              m1;
	logic              io_wr;
	logic              mem_wr;
	logic              mem_rd;
	cpu_addr_t         cpu_addr;
	sdram_addr_t       ram_a;
	byte_t             cpu_dout;
	logic              nmi;
	logic              mf2_active;
	byte_t             mf2_dout;
	logic              sd_we;
	logic              sd_oe;
	sdram_addr_t       sd_addr;
	bank_t             sd_bank;
	byte_t             sd_din;

	int         timeouts = 0;
	logic       loaded [0:255]; // Upper ROM pages written so far
	int         last_upper;
	byte_t      shadow [int];
	logic [4:0] pen;
	logic [3:0] crtc;

	cpc_mem_top DUT (.*);
	tb_checker chk (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Inputs change 1 ns after the edge
	task automatic step();
		@(posedge clk_sys);
		#1;
		mem_slot = ($urandom % 4) == 0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (dl_wait !== 1'b0) begin
			if (n == 200) begin
				timeouts++;
				$display("Timeout: dl_wait stayed high at %0t", $time);
				return;
			end
			n++;
			step();
		end
	endtask

	task automatic wait_active(input logic v);
		int n;
		n = 0;
		while (mf2_active !== v) begin
			if (n == 50) begin
				timeouts++;
				$display("Timeout: mf2_active never became %b at %0t", v, $time);
				return;
			end
			n++;
			step();
		end
	endtask

	////////////////////
	// Loader model

	function automatic rom_page_t sys_page(input int c);
		case (c % 4)
			0:       return `SYS_ROM_PAGE0;
			1:       return `SYS_ROM_PAGE1;
			2:       return `SYS_ROM_PAGE2;
			default: return `SYS_ROM_PAGE3;
		endcase
	endfunction

	function automatic int hex_val(input byte_t c);
		if (c >= "0" && c <= "9") return c - "0";
		if (c >= "A" && c <= "F") return c - "A" + 10;
		if (c >= "a" && c <= "f") return c - "a" + 10;
		return -1;
	endfunction

	function automatic rom_page_t ext_page_of(input logic [15:0] ext);
		int hi;
		int lo;
		hi = hex_val(ext[15:8]);
		lo = hex_val(ext[7:0]);
		if (ext == "ZZ") return 9'h000;
		if (hi < 0 || lo < 0) return `PAGE_BAD;
		return {1'b1, hi[3:0], lo[3:0]};
	endfunction

	function automatic logic [15:0] rand_hex_ext();
		string digits;
		digits = "0123456789abcdefABCDEF";
		return {digits[$urandom % 22], digits[$urandom % 22]};
	endfunction

	task automatic send_byte(input logic [`DL_AW-1:0] a, input byte_t d, input logic taken);
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		step();
		dl_wr = 1'b0;
		chk.expect_wait(taken); // Busy from the cycle after the byte
		wait_idle();
	endtask

	task automatic sys_download();
		rom_page_t   pg;
		logic [13:0] ofs;
		byte_t       d;
		dl_index    = 8'd0;
		dl_file_ext = "  ";
		dl_active   = 1'b1;
		step();
		for (int c = 0; c < 10; c++) begin
			for (int k = 0; k < 3; k++) begin
				ofs = $urandom;
				d   = $urandom;
				pg  = sys_page(c);
				if (c < 8) begin // Chunks past 7 are ignored
					chk.expect_write({pg, ofs}, c[2], d);
					if (pg[8]) loaded[pg[7:0]] = 1'b1;
				end
				send_byte({c[10:0], ofs}, d, c < 8);
			end
		end
		dl_active = 1'b0;
		step();
	endtask

	task automatic exp_download(input logic [15:0] ext, input int n);
		rom_page_t   pg;
		sdram_addr_t a;
		logic [13:0] ofs;
		logic [7:0]  ch;
		byte_t       d;
		pg          = ext_page_of(ext);
		dl_index    = 8'd1;
		dl_file_ext = ext;
		dl_active   = 1'b1;
		step();
		for (int i = 0; i < n; i++) begin
			ofs = $urandom;
			ch  = $urandom % 2;
			d   = $urandom;
			a   = {pg[8], pg[7:0] + ch, ofs};
			chk.expect_write(a, 1'b0, d); // Both banks get the byte
			chk.expect_write(a, 1'b1, d);
			if (pg[8]) begin
				loaded[a[21:14]] = 1'b1;
				last_upper = a[21:14];
			end
			send_byte({3'b000, ch, ofs}, d, 1'b1);
		end
		dl_active = 1'b0;
		step();
	endtask

	task automatic read_oe(input sdram_addr_t a, input logic e);
		ram_a  = a;
		mem_rd = 1'b1;
		chk.expect_oe(e);
		step();
		mem_rd = 1'b0;
	endtask

	////////////////////
	// Freezer stimulus

	task automatic pulse_key(input logic exp_nmi);
		key_nmi = 1'b1;
		step();
		key_nmi = 1'b0;
		chk.expect_flags(exp_nmi, 1'b0);
		step();
	endtask

	task automatic m1_fetch(input cpu_addr_t a);
		cpu_addr = a;
		m1       = 1'b1;
		step();
		m1 = 1'b0;
		step();
	endtask

	task automatic io_write(input cpu_addr_t a, input byte_t d);
		cpu_addr = a;
		cpu_dout = d;
		io_wr    = 1'b1;
		step();
		io_wr = 1'b0;
		step();
	endtask

	task automatic shadow_write();
		logic [7:0] hi;
		byte_t      d;
		int         ofs;
		d = $urandom;
		case ($urandom % 5)
			0: begin
				hi = 8'h7F;
				case (d[7:6])
					2'b00: begin
						ofs = `MF2_OFS_PEN_IDX;
						pen = d[4:0];
					end
					2'b01:   ofs = pen[4] ? `MF2_OFS_BORDER : `MF2_OFS_PEN_COL + pen[3:0];
					2'b10:   ofs = `MF2_OFS_MODE;
					default: ofs = `MF2_OFS_BANKING;
				endcase
			end
			1: begin
				hi   = 8'hBC;
				d    = d % 16;
				ofs  = `MF2_OFS_CRTC_SEL;
				crtc = d[3:0];
			end
			2: begin
				hi  = 8'hBD;
				ofs = `MF2_OFS_CRTC_VAL + crtc;
			end
			3: begin
				hi  = 8'hF7;
				ofs = `MF2_OFS_PPI;
			end
			default: begin
				hi  = 8'hDF;
				ofs = `MF2_OFS_UROM;
			end
		endcase
		shadow[ofs] = d;
		io_write({hi, 8'($urandom)}, d);
	endtask

	task automatic freezer_tests();
		byte_t d;
		mf2_mode = 2'd0;
		pulse_key(1'b1);
		m1_fetch(`MF2_NMI_VEC);
		wait_active(1'b1);
		chk.expect_flags(1'b0, 1'b1);
		step();
		for (int i = 0; i < 40; i++) shadow_write();
		foreach (shadow[o]) begin
			cpu_addr = 16'h2000 | o[12:0];
			ram_a    = o;
			mem_rd   = 1'b1;
			step();
			mem_rd = 1'b0;
			chk.expect_dout(shadow[o]);
			step();
		end
		cpu_addr = 16'h4000; // Outside the RAM window
		mem_rd   = 1'b1;
		step();
		mem_rd = 1'b0;
		chk.expect_dout(8'hFF);
		step();
		// Freezer windows must not reach SDRAM
		for (int i = 0; i < 8; i++) begin
			cpu_addr = $urandom % 16'h4000;
			ram_a    = $urandom;
			mem_wr   = 1'b1;
			step();
			mem_wr = 1'b0;
			cpu_addr = $urandom % 16'h2000;
			ram_a    = $urandom;
			mem_rd   = 1'b1;
			chk.expect_addr({`MF2_ROM_PAGE, ram_a[13:0]});
			chk.expect_oe(loaded[8'hFF]);
			step();
			mem_rd = 1'b0;
		end
		io_write(`MF2_CTRL_PORT | 16'h0002, 8'h00);
		wait_active(1'b0);

		// Hidden freezer ignores the control port
		pulse_key(1'b1);
		m1_fetch(`MF2_NMI_VEC);
		wait_active(1'b1);
		m1_fetch(`MF2_HIDE_VEC);
		wait_active(1'b0);
		io_write(`MF2_CTRL_PORT | 16'h0002, 8'h00);
		pulse_key(1'b1);
		m1_fetch(`MF2_NMI_VEC);
		wait_active(1'b1);
		mf2_mode = 2'd1; // Exit forbidden
		io_write(`MF2_CTRL_PORT | 16'h0002, 8'h00);
		chk.expect_flags(1'b0, 1'b1);
		step();
		mf2_mode = 2'd0;
		io_write(`MF2_CTRL_PORT | 16'h0002, 8'h00);
		wait_active(1'b0);
		mf2_mode = 2'd2;
		pulse_key(1'b0);

		// Plain CPU write uses the bank latched in reset
		cpu_addr = 16'h8000;
		ram_a    = $urandom & 23'h3FFFFF;
		d        = $urandom;
		cpu_dout = d;
		chk.expect_write(ram_a, 1'b1, d);
		mem_wr = 1'b1;
		step();
		mem_wr = 1'b0;
		step();
	endtask

	initial begin
		int p;
		void'($urandom(2));
		reset = 1'b1;
		mem_slot = 1'b0;
		model = 1'b1;
		mf2_mode = 2'd0;
		dl_active = 1'b0;
		dl_index = '0;
		dl_file_ext = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		key_nmi = 1'b0;
		m1 = 1'b0;
		io_wr = 1'b0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		cpu_addr = '0;
		ram_a = '0;
		cpu_dout = '0;
		pen = '0;
		crtc = '0;
		last_upper = 0;
		foreach (loaded[i]) loaded[i] = 1'b0;
		repeat (8) step();
		reset = 1'b0;
		model = 1'b0; // Bank must stay as latched in reset
		step();

		sys_download();
		exp_download(rand_hex_ext(), 6);
		exp_download(rand_hex_ext(), 6);
		exp_download("ZZ", 4);
		exp_download("G7", 4);
		exp_download("3x", 2);
		exp_download(rand_hex_ext(), 6); // Ends on an upper page when valid

		read_oe({1'b1, 8'(last_upper), 14'($urandom)}, loaded[last_upper]);
		p = $urandom % 256;
		for (int i = 0; i < 256 && loaded[p]; i++) p = (p + 1) % 256;
		read_oe({1'b1, 8'(p), 14'($urandom)}, loaded[p]);

		freezer_tests();
		chk.drain_check();
		step();

		$display("Checks done: %0d errors, %0d timeouts", chk.errors, timeouts);
		if (chk.errors == 0 && timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- tb_checker.sv
// Testbench output checker
`include "cpc_mem_macros.svh"

module tb_checker
	import cpc_mem_pkg::*;
(
	input logic        clk_sys,
	input logic        dl_wait,
	input logic        sd_we,
	input logic        sd_oe,
	input sdram_addr_t sd_addr,
	input bank_t       sd_bank,
	input byte_t       sd_din,
	input logic        nmi,
	input logic        mf2_active,
	input byte_t       mf2_dout
);

	timeunit 1ns;
	timeprecision 100ps;

	int          errors = 0;
	logic [31:0] wr_q [$]; // {bank, addr, data} in expected order
	logic [31:0] wr_exp;
	logic        chk_oe = 1'b0;
	logic        exp_oe;
	logic        chk_addr = 1'b0;
	sdram_addr_t exp_addr;
	logic        chk_dout = 1'b0;
	byte_t       exp_dout;
	logic        chk_flags = 1'b0;
	logic        exp_nmi;
	logic        exp_active;
	logic        chk_wait = 1'b0;
	logic        exp_wait;

	task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("ERR t=%0t %s got=%h expected=%h", $time, name, got, exp);
	endtask

	////////////////////
	// Expectations from the model

	task automatic expect_write(input sdram_addr_t a, input bank_t b, input byte_t d);
		wr_q.push_back({b, a, d});
	endtask

	task automatic expect_oe(input logic e);
		exp_oe = e;
		chk_oe = 1'b1;
	endtask

	task automatic expect_addr(input sdram_addr_t a);
		exp_addr = a;
		chk_addr = 1'b1;
	endtask

	task automatic expect_dout(input byte_t d);
		exp_dout = d;
		chk_dout = 1'b1;
	endtask

	task automatic expect_flags(input logic n, input logic a);
		exp_nmi    = n;
		exp_active = a;
		chk_flags  = 1'b1;
	endtask

	task automatic expect_wait(input logic w);
		exp_wait = w;
		chk_wait = 1'b1;
	endtask

	task automatic drain_check();
		if (wr_q.size() != 0) begin
			errors++;
			$display("%0d expected SDRAM writes never happened", wr_q.size());
		end
	endtask

	////////////////////
	// Compare mid cycle, outputs are settled

	always @(negedge clk_sys) begin
		if (sd_we === 1'b1) begin
			if (wr_q.size() == 0) begin
				errors++;
				$display("Unexpected SDRAM write at %0t to address %h", $time, sd_addr);
			end else begin
				wr_exp = wr_q.pop_front();
				if (sd_addr !== wr_exp[30:8]) report("sd_addr", sd_addr, wr_exp[30:8]);
				if (sd_bank !== wr_exp[31])   report("sd_bank", sd_bank, wr_exp[31]);
				if (sd_din !== wr_exp[7:0])   report("sd_din", sd_din, wr_exp[7:0]);
			end
		end
		if (chk_oe) begin
			if (sd_oe !== exp_oe) report("sd_oe", sd_oe, exp_oe);
			chk_oe = 1'b0;
		end
		if (chk_addr) begin
			if (sd_addr !== exp_addr) report("sd_addr", sd_addr, exp_addr);
			chk_addr = 1'b0;
		end
		if (chk_dout) begin
			if (mf2_dout !== exp_dout) report("mf2_dout", mf2_dout, exp_dout);
			chk_dout = 1'b0;
		end
		if (chk_flags) begin
			if (nmi !== exp_nmi)           report("nmi", nmi, exp_nmi);
			if (mf2_active !== exp_active) report("mf2_active", mf2_active, exp_active);
			chk_flags = 1'b0;
		end
		if (chk_wait) begin
			if (dl_wait !== exp_wait) report("dl_wait", dl_wait, exp_wait);
			chk_wait = 1'b0;
		end
	end

endmodule

//--- cpc_mem_asserts.sv
// Handshake assertions
module cpc_mem_asserts (
	input logic clk_sys,
	input logic reset,
	input logic mem_slot,
	input logic req,
	input logic accept,
	input logic sd_we,
	input logic sd_oe,
	input logic dl_wr,
	input logic dl_wait
);

	timeunit 1ns;
	timeprecision 100ps;

	a_accept: assert property (@(posedge clk_sys) disable iff (reset)
		accept |-> (req && mem_slot))
		else $error("accept seen without req and mem_slot");

	a_excl: assert property (@(posedge clk_sys) disable iff (reset) !(sd_we && sd_oe))
		else $error("sd_we and sd_oe high together");

	// Host must respect back-pressure
	a_host: assert property (@(posedge clk_sys) disable iff (reset) dl_wr |-> !dl_wait)
		else $error("dl_wr pulsed while dl_wait was high");

endmodule

bind sdram_arbiter cpc_mem_asserts arb_checks (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.mem_slot (mem_slot),
	.req      (boot.req),
	.accept   (boot.accept),
	.sd_we    (sd_we),
	.sd_oe    (sd_oe),
	.dl_wr    (1'b0),
	.dl_wait  (1'b0)
);

bind rom_loader cpc_mem_asserts ld_checks (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.mem_slot (1'b1),
	.req      (boot.req),
	.accept   (boot.accept),
	.sd_we    (1'b0),
	.sd_oe    (1'b0),
	.dl_wr    (dl_wr),
	.dl_wait  (dl_wait)
);

//--- cpc_mem_top.sv
// CPC memory glue top level
`include "cpc_mem_macros.svh"

module cpc_mem_top
	import cpc_mem_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              mem_slot,
	input  bank_t             model,
	input  logic [1:0]        mf2_mode,

	// Host download port
	input  logic              dl_active,
	input  byte_t             dl_index,
	input  logic [15:0]       dl_file_ext,
	input  logic              dl_wr,
	input  logic [`DL_AW-1:0] dl_addr,
	input  byte_t             dl_data,
	output logic              dl_wait,

	// CPU side
	input  logic              key_nmi,
	input  logic              m1,
	input  logic              io_wr,
	input  logic              mem_wr,
	input  logic              mem_rd,
	input  cpu_addr_t         cpu_addr,
	input  sdram_addr_t       ram_a,
	input  byte_t             cpu_dout,
	output logic              nmi,
	output logic              mf2_active,
	output byte_t             mf2_dout,

	// SDRAM command
	output logic              sd_we,
	output logic              sd_oe,
	output sdram_addr_t       sd_addr,
	output bank_t             sd_bank,
	output byte_t             sd_din
);

	logic rom_sel;
	logic ram_sel;

	boot_if boot ();

	rom_loader loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_file_ext (dl_file_ext),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wait     (dl_wait),
		.boot        (boot.loader)
	);

	mf2_freezer freezer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mf2_mode (mf2_mode),
		.key_nmi  (key_nmi),
		.m1       (m1),
		.io_wr    (io_wr),
		.mem_wr   (mem_wr),
		.mem_rd   (mem_rd),
		.cpu_addr (cpu_addr),
		.ram_addr (ram_a[`MF2_RAM_AW-1:0]), // Offset inside the RAM window
		.cpu_dout (cpu_dout),
		.nmi      (nmi),
		.active   (mf2_active),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel),
		.mf2_dout (mf2_dout)
	);

	sdram_arbiter arbiter (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mem_slot (mem_slot),
		.model    (model),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.ram_a    (ram_a),
		.cpu_dout (cpu_dout),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel),
		.boot     (boot.arbiter),
		.sd_we    (sd_we),
		.sd_oe    (sd_oe),
		.sd_addr  (sd_addr),
		.sd_bank  (sd_bank),
		.sd_din   (sd_din)
	);

endmodule

//--- sdram_arbiter.sv
// SDRAM request arbiter
`include "cpc_mem_macros.svh"

module sdram_arbiter
	import cpc_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        mem_slot,
	input  bank_t       model,
	input  logic        mem_rd,
	input  logic        mem_wr,
	input  sdram_addr_t ram_a,
	input  byte_t       cpu_dout,
	input  logic        rom_sel,
	input  logic        ram_sel,
	boot_if.arbiter     boot,
	output logic        sd_we,
	output logic        sd_oe,
	output sdram_addr_t sd_addr,
	output bank_t       sd_bank,
	output byte_t       sd_din
);

	logic         boot_mode;
	bank_t        bank_q;
	sdram_addr_t  cpu_sd_addr;
	logic         rom_mask;
	logic [255:0] loaded_map = '0; // One flag per upper ROM page

	assign boot.accept = boot.req && mem_slot;
	assign boot_mode   = reset || boot.active;

	// Machine model is sampled only while in reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			bank_q <= model;
	end

	////////////////////
	// Loaded page map

	always_ff @(posedge clk_sys) begin
		if (boot.accept && boot.addr[`SDRAM_AW-1])
			loaded_map[boot.addr[`SDRAM_AW-2:`ROM_PAGE_W]] <= 1'b1;
	end

	////////////////////
	// Command mux

	// Freezer ROM window maps onto its own page
	assign cpu_sd_addr = rom_sel ? {`MF2_ROM_PAGE, ram_a[`ROM_PAGE_W-1:0]} : ram_a;

	assign rom_mask = cpu_sd_addr[`SDRAM_AW-1] &&
		!loaded_map[cpu_sd_addr[`SDRAM_AW-2:`ROM_PAGE_W]];

	always_comb begin
		if (boot_mode) begin
			sd_we   = boot.accept;
			sd_oe   = 1'b0;
			sd_addr = boot.addr;
			sd_bank = boot.bank;
			sd_din  = boot.data;
		end else begin
			sd_we   = mem_wr && !ram_sel && !rom_sel; // Freezer windows are not SDRAM
			sd_oe   = mem_rd && !ram_sel && !rom_mask;
			sd_addr = cpu_sd_addr;
			sd_bank = bank_q;
			sd_din  = cpu_dout;
		end
	end

endmodule

//--- mf2_freezer.sv
// Multiface freezer
`include "cpc_mem_macros.svh"

module mf2_freezer
	import cpc_mem_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [1:0] mf2_mode, // 0 enabled, 1 hidden, 2 or 3 disabled
	input  logic       key_nmi,
	input  logic       m1,
	input  logic       io_wr,
	input  logic       mem_wr,
	input  logic       mem_rd,
	input  cpu_addr_t  cpu_addr,
	input  mf2_addr_t  ram_addr,
	input  byte_t      cpu_dout,
	output logic       nmi,
	output logic       active,
	output logic       rom_sel,
	output logic       ram_sel,
	output byte_t      mf2_dout
);

	mf2_state_t state;
	logic       key_nmi_q;
	logic       m1_q;
	logic       io_wr_q;
	logic       key_rise;
	logic       m1_rise;
	logic       io_rise;
	logic       nmi_allowed;
	logic       ctrl_hit;
	logic       store_hit;
	logic       store_en;
	mf2_addr_t  store_addr;
	logic [4:0] pen_index; // Bit 4 selects the border
	logic [3:0] crtc_reg;
	byte_t      mf2_ram [0:2**`MF2_RAM_AW-1];
	mf2_addr_t  mem_a;
	logic       mem_we;
	byte_t      ram_q;
	logic       rd_sel_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_nmi_q <= 1'b0;
			m1_q      <= 1'b0;
			io_wr_q   <= 1'b0;
		end else begin
			key_nmi_q <= key_nmi;
			m1_q      <= m1;
			io_wr_q   <= io_wr;
		end
	end

	assign key_rise    = key_nmi && !key_nmi_q;
	assign m1_rise     = m1 && !m1_q;
	assign io_rise     = io_wr && !io_wr_q;
	assign nmi_allowed = !mf2_mode[1];
	assign ctrl_hit    = io_rise && ((cpu_addr & ~16'h0003) == `MF2_CTRL_PORT);

	////////////////////
	// Freezer FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle, st_hidden:
					if (key_rise && nmi_allowed)
						state <= st_nmi_pending;
				st_nmi_pending:
					if (m1_rise && cpu_addr == `MF2_NMI_VEC)
						state <= st_active;
				default:
					if (m1_rise && cpu_addr == `MF2_HIDE_VEC)
						state <= st_hidden;
					else if (ctrl_hit && cpu_addr[1] && mf2_mode == 2'd0)
						state <= st_idle; // Exit through 0xFEEA
			endcase
		end
	end

	assign nmi     = (state == st_nmi_pending);
	assign active  = (state == st_active);
	assign rom_sel = active && (cpu_addr[15:13] == 3'b000); // 0x0000 to 0x1FFF
	assign ram_sel = active && (cpu_addr[15:13] == 3'b001); // 0x2000 to 0x3FFF

	////////////////////
	// Shadow register capture

	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (cpu_addr[15:8])
			8'h7F: begin // Gate array
				case (cpu_dout[7:6])
					2'b00: store_addr = `MF2_OFS_PEN_IDX;
					2'b01: store_addr = pen_index[4] ? `MF2_OFS_BORDER :
						`MF2_OFS_PEN_COL + {9'd0, pen_index[3:0]};
					2'b10: store_addr = `MF2_OFS_MODE;
					default: store_addr = `MF2_OFS_BANKING;
				endcase
			end
			8'hBC: store_addr = `MF2_OFS_CRTC_SEL;
			8'hBD: store_addr = `MF2_OFS_CRTC_VAL + {9'd0, crtc_reg};
			8'hF7: store_addr = `MF2_OFS_PPI;
			8'hDF: store_addr = `MF2_OFS_UROM;
			default: store_hit = 1'b0;
		endcase
	end

	assign store_en = io_rise && store_hit;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (store_en) begin
			if (cpu_addr[15:8] == 8'h7F && cpu_dout[7:6] == 2'b00)
				pen_index <= cpu_dout[4:0];
			if (cpu_addr[15:8] == 8'hBC)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	////////////////////
	// 8 KiB freezer RAM

	always_comb begin
		mem_we = 1'b0;
		mem_a  = ram_addr;
		if (store_en) begin
			mem_we = 1'b1; // Capture wins over a CPU write
			mem_a  = store_addr;
		end else if (mem_wr && ram_sel) begin
			mem_we = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mem_we)
			mf2_ram[mem_a] <= cpu_dout;
		ram_q <= mf2_ram[mem_a];
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_sel_q <= 1'b0;
		else
			rd_sel_q <= ram_sel && mem_rd;
	end

	assign mf2_dout = rd_sel_q ? ram_q : 8'hFF; // Idle bus reads high

endmodule

//--- rom_loader.sv
// ROM download loader
`include "cpc_mem_macros.svh"

module rom_loader
	import cpc_mem_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              dl_active,
	input  byte_t             dl_index,
	input  logic [15:0]       dl_file_ext, // Two characters
	input  logic              dl_wr,
	input  logic [`DL_AW-1:0] dl_addr,
	input  byte_t             dl_data,
	output logic              dl_wait,
	boot_if.loader            boot
);

	typedef enum logic [1:0] {
		ld_idle,
		ld_first,  // First copy offered to the arbiter
		ld_second  // Upper bank copy of an expansion ROM
	} ld_state_t;

	ld_state_t   ld_state;
	logic        exp_rom;
	logic        dl_active_q;
	rom_page_t   exp_page;
	rom_page_t   ext_page;
	rom_page_t   sys_page;
	logic [4:0]  nib_hi;
	logic [4:0]  nib_lo;
	logic [`DL_AW-`ROM_PAGE_W-1:0] chunk;
	logic        sys_valid;
	logic        byte_take;
	sdram_addr_t byte_addr;
	bank_t       byte_bank;
	sdram_addr_t addr_q;
	bank_t       bank_q;
	byte_t       data_q;

	// Bit 4 flags a valid hex digit
	function automatic logic [4:0] hex_nibble(input byte_t c);
		logic [4:0] r;
		r = 5'h00;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f"))
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	////////////////////
	// Expansion page from the file extension

	always_comb begin
		nib_hi = hex_nibble(dl_file_ext[15:8]);
		nib_lo = hex_nibble(dl_file_ext[7:0]);
		if (dl_file_ext == "ZZ")
			ext_page = '0;
		else if (nib_hi[4] && nib_lo[4])
			ext_page = {1'b1, nib_hi[3:0], nib_lo[3:0]}; // Upper ROM area
		else
			ext_page = `PAGE_BAD;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			dl_active_q <= 1'b0;
		else
			dl_active_q <= dl_active;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_active && !dl_active_q)
			exp_page <= ext_page;
	end

	////////////////////
	// Byte address

	assign chunk     = dl_addr[`DL_AW-1:`ROM_PAGE_W];
	assign sys_valid = (chunk < 8);

	always_comb begin
		case (chunk[1:0])
			2'd0:    sys_page = `SYS_ROM_PAGE0;
			2'd1:    sys_page = `SYS_ROM_PAGE1;
			2'd2:    sys_page = `SYS_ROM_PAGE2;
			default: sys_page = `SYS_ROM_PAGE3;
		endcase
	end

	always_comb begin
		byte_addr[`ROM_PAGE_W-1:0] = dl_addr[`ROM_PAGE_W-1:0];
		if (dl_index != 0) begin
			byte_addr[`SDRAM_AW-1] = exp_page[8];
			byte_addr[`SDRAM_AW-2:`ROM_PAGE_W] = exp_page[7:0] +
				dl_addr[`ROM_PAGE_W+7:`ROM_PAGE_W];
			byte_bank = 1'b0;
		end else begin
			byte_addr[`SDRAM_AW-1:`ROM_PAGE_W] = sys_page;
			byte_bank = chunk[2]; // Chunks 4 to 7 fill the upper bank
		end
	end

	// Chunks past the eighth are dropped silently
	assign byte_take = dl_active && dl_wr && (ld_state == ld_idle) &&
		((dl_index != 0) || sys_valid);

	////////////////////
	// Write request FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ld_state <= ld_idle;
			dl_wait  <= 1'b0;
			exp_rom  <= 1'b0;
		end else begin
			case (ld_state)
				ld_idle: if (byte_take) begin
					ld_state <= ld_first;
					dl_wait  <= 1'b1;
					exp_rom  <= (dl_index != 0);
				end
				ld_first: if (boot.accept) begin
					if (exp_rom) begin
						ld_state <= ld_second;
					end else begin
						ld_state <= ld_idle;
						dl_wait  <= 1'b0;
					end
				end
				default: if (boot.accept) begin
					ld_state <= ld_idle;
					dl_wait  <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_take) begin
			addr_q <= byte_addr;
			bank_q <= byte_bank;
			data_q <= dl_data;
		end else if (ld_state == ld_first && boot.accept && exp_rom) begin
			bank_q <= 1'b1;
		end
	end

	assign boot.active = dl_active || (ld_state != ld_idle); // Covers the last write
	assign boot.req    = (ld_state != ld_idle);
	assign boot.addr   = addr_q;
	assign boot.bank   = bank_q;
	assign boot.data   = data_q;

endmodule

//--- boot_if.sv
// Loader to arbiter write channel
interface boot_if
	import cpc_mem_pkg::*;
();

	logic        active; // ROM download in progress
	logic        req;
	sdram_addr_t addr;
	bank_t       bank;
	byte_t       data;
	logic        accept; // One cycle, taken in a memory slot

	modport loader (
		output active, req, addr, bank, data,
		input  accept
	);

	modport arbiter (
		input  active, req, addr, bank, data,
		output accept
	);

endinterface

//--- cpc_mem_pkg.sv
// CPC memory glue types
`include "cpc_mem_macros.svh"

package cpc_mem_pkg;

	////////////////////
	// Address and data vectors

	typedef logic [`SDRAM_AW-1:0] sdram_addr_t;
	typedef logic [`CPU_AW-1:0]   cpu_addr_t;
	typedef logic [7:0]           byte_t;

	// Bit 8 marks the upper ROM area
	typedef logic [`SDRAM_AW-`ROM_PAGE_W-1:0] rom_page_t;

	typedef logic [`MF2_RAM_AW-1:0] mf2_addr_t;

	typedef logic bank_t; // 64 KiB or 128 KiB bank

	////////////////////
	// Freezer control

	typedef enum logic [1:0] {
		st_idle,
		st_nmi_pending, // NMI raised, waiting for the vector fetch
		st_active,      // Freezer ROM and RAM paged in
		st_hidden       // Paged out and deaf to the control port
	} mf2_state_t;

endpackage

//--- cpc_mem_macros.svh
// CPC memory glue constants
`ifndef CPC_MEM_MACROS_SVH
`define CPC_MEM_MACROS_SVH

`define SDRAM_AW         23 // SDRAM byte address
`define CPU_AW           16
`define DL_AW            25 // Host download address
`define ROM_PAGE_W       14 // Offset inside a 16 KiB page
`define MF2_RAM_AW       13

`define PAGE_BAD         9'h1EE // Landing page for a bad extension
`define SYS_ROM_PAGE0    9'h000 // OS
`define SYS_ROM_PAGE1    9'h100 // BASIC
`define SYS_ROM_PAGE2    9'h107 // AMSDOS
`define SYS_ROM_PAGE3    9'h1FF // Freezer ROM
`define MF2_ROM_PAGE     `SYS_ROM_PAGE3

`define MF2_NMI_VEC      16'h0066
`define MF2_HIDE_VEC     16'h0065
`define MF2_CTRL_PORT    16'hFEE8 // Bit 1 set selects 0xFEEA

// Shadow copies of write-only hardware registers
`define MF2_OFS_PEN_IDX  13'h1FCF
`define MF2_OFS_PEN_COL  13'h1F90
`define MF2_OFS_BORDER   13'h1FDF
`define MF2_OFS_MODE     13'h1FEF
`define MF2_OFS_BANKING  13'h1FFF
`define MF2_OFS_CRTC_SEL 13'h1CFF
`define MF2_OFS_CRTC_VAL 13'h1DB0
`define MF2_OFS_PPI      13'h17FF
`define MF2_OFS_UROM     13'h1AAC

`endif
